//--- verilog/decoderPkg.sv
`default_nettype none

package decoderPkg;

  // Widths with a meaning in the datapath
  typedef logic [31:0] instrT;
  typedef logic [5:0]  opcodeT;
  typedef logic [4:0]  aluCtrlT;
  typedef logic [3:0]  byteEnT;
  typedef logic [1:0]  extModeT;
  typedef logic [1:0]  aluSrcBT;
  typedef logic [2:0]  instrClassT;

  typedef enum logic [2:0] {
    stFetch   = 3'b000,
    stDecode  = 3'b001,
    stExec1   = 3'b010,
    stExec2   = 3'b011,
    stExec3   = 3'b100,
    stHalted  = 3'b101,
    stMemWait = 3'b110
  } stepT;

  // Opcode field position in the instruction word
  localparam int opcodeMsb = 31;
  localparam int opcodeLsb = 26;

  // Primary opcodes, branch codes as the datapath decodes them
  localparam opcodeT opAddiu = 6'b001001;
  localparam opcodeT opAndi  = 6'b001100;
  localparam opcodeT opOri   = 6'b001101;
  localparam opcodeT opXori  = 6'b001110;
  localparam opcodeT opLw    = 6'b100011;
  localparam opcodeT opLb    = 6'b100000;
  localparam opcodeT opLbu   = 6'b100100;
  localparam opcodeT opSw    = 6'b101011;
  localparam opcodeT opBeq   = 6'b000101;
  localparam opcodeT opBne   = 6'b000100;
  localparam opcodeT opJ     = 6'b000010;

  // ALU operation codes
  localparam aluCtrlT aluAnd          = 5'b00000;
  localparam aluCtrlT aluOr           = 5'b00001;
  localparam aluCtrlT aluAdd          = 5'b00010;
  localparam aluCtrlT aluXor          = 5'b00011;
  localparam aluCtrlT aluCmpEq        = 5'b01010;
  localparam aluCtrlT aluBranchTarget = 5'b01101;
  localparam aluCtrlT aluPassB        = 5'b10001;

  // Instruction classes
  localparam instrClassT clsAluImm   = 3'd0;
  localparam instrClassT clsLoad     = 3'd1;
  localparam instrClassT clsStore    = 3'd2;
  localparam instrClassT clsBranchEq = 3'd3;
  localparam instrClassT clsBranchNe = 3'd4;
  localparam instrClassT clsJump     = 3'd5;
  localparam instrClassT clsUnknown  = 3'd7;

  // Load extension and B-operand selects
  localparam extModeT extNone     = 2'd0;
  localparam extModeT extSignByte = 2'd2;

  localparam aluSrcBT srcBReg   = 2'd0;
  localparam aluSrcBT srcBFour  = 2'd1;
  localparam aluSrcBT srcBImm   = 2'd2;
  localparam aluSrcBT srcBShift = 2'd3;

endpackage

`default_nettype wire

//--- verilog/opcodeClassifier.sv
`default_nettype none

module opcodeClassifier (
  input  decoderPkg::opcodeT     opcode,
  output decoderPkg::instrClassT instrClass,
  output decoderPkg::aluCtrlT    aluOp,
  output logic                   extSel,
  output decoderPkg::byteEnT     byteEnable,
  output decoderPkg::extModeT    extendMode
);

  always_comb begin
    // Word access, sign-extended immediate, address add
    instrClass = decoderPkg::clsUnknown;
    aluOp      = decoderPkg::aluAdd;
    extSel     = 1'b0;
    byteEnable = 4'b1111;
    extendMode = decoderPkg::extNone;

    case (opcode)
      decoderPkg::opAddiu: begin
        instrClass = decoderPkg::clsAluImm;
      end
      decoderPkg::opAndi: begin
        instrClass = decoderPkg::clsAluImm;
        aluOp      = decoderPkg::aluAnd;
        extSel     = 1'b1;
      end
      decoderPkg::opOri: begin
        instrClass = decoderPkg::clsAluImm;
        aluOp      = decoderPkg::aluOr;
        extSel     = 1'b1;
      end
      decoderPkg::opXori: begin
        instrClass = decoderPkg::clsAluImm;
        aluOp      = decoderPkg::aluXor;
        extSel     = 1'b1;
      end
      decoderPkg::opLw: begin
        instrClass = decoderPkg::clsLoad;
      end
      decoderPkg::opLb: begin
        instrClass = decoderPkg::clsLoad;
        byteEnable = 4'b0001;
        extendMode = decoderPkg::extSignByte;
      end
      decoderPkg::opLbu: begin
        // Zero-extended byte
        instrClass = decoderPkg::clsLoad;
        byteEnable = 4'b0001;
      end
      decoderPkg::opSw:  instrClass = decoderPkg::clsStore;
      decoderPkg::opBeq: instrClass = decoderPkg::clsBranchEq;
      decoderPkg::opBne: instrClass = decoderPkg::clsBranchNe;
      decoderPkg::opJ:   instrClass = decoderPkg::clsJump;
      default: begin
        instrClass = decoderPkg::clsUnknown;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/controlSequencer.sv
`default_nettype none

module controlSequencer (
  input  logic                   clk,
  input  logic                   reset,
  input  decoderPkg::instrClassT instrClass,
  input  logic                   waitRequest,
  input  logic                   outLsb,
  input  logic                   pcIsZero,
  output decoderPkg::stepT       step,
  output logic                   branchDelay,
  output logic                   active
);

  decoderPkg::stepT stepNext;
  logic             branchDelayNext;
  logic             isLoad;
  logic             needsExtra;

  assign isLoad     = (instrClass == decoderPkg::clsLoad);
  // ALU-immediate, load and store continue past the first execute step
  assign needsExtra = (instrClass == decoderPkg::clsAluImm) || isLoad ||
                      (instrClass == decoderPkg::clsStore);

  assign active = (step != decoderPkg::stHalted);

  always_comb begin
    stepNext = step;
    case (step)
      decoderPkg::stFetch,
      decoderPkg::stMemWait: begin
        stepNext = waitRequest ? decoderPkg::stMemWait : decoderPkg::stDecode;
      end
      decoderPkg::stDecode: stepNext = decoderPkg::stExec1;
      decoderPkg::stExec1: begin
        stepNext = needsExtra ? decoderPkg::stExec2 : decoderPkg::stFetch;
      end
      decoderPkg::stExec2: begin
        // Only a load waits on the data read
        if (isLoad) begin
          stepNext = waitRequest ? decoderPkg::stExec2 : decoderPkg::stExec3;
        end else begin
          stepNext = decoderPkg::stFetch;
        end
      end
      decoderPkg::stExec3:  stepNext = decoderPkg::stFetch;
      decoderPkg::stHalted: stepNext = decoderPkg::stHalted;
      default:              stepNext = decoderPkg::stHalted;
    endcase

    if (pcIsZero && (step != decoderPkg::stHalted)) begin
      stepNext = decoderPkg::stHalted;
    end
  end

  always_comb begin
    branchDelayNext = branchDelay;
    case (step)
      decoderPkg::stExec1: begin
        case (instrClass)
          decoderPkg::clsJump:     branchDelayNext = 1'b1;
          decoderPkg::clsBranchEq: branchDelayNext = outLsb;
          decoderPkg::clsBranchNe: branchDelayNext = !outLsb;
          default: begin
            // Unknown opcodes end here
            if (!needsExtra) begin
              branchDelayNext = 1'b0;
            end
          end
        endcase
      end
      decoderPkg::stExec2: begin
        if (!isLoad) begin
          branchDelayNext = 1'b0;
        end
      end
      decoderPkg::stExec3: branchDelayNext = 1'b0;
      default:             branchDelayNext = branchDelay;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      step        <= decoderPkg::stFetch;
      branchDelay <= 1'b0;
    end else begin
      step        <= stepNext;
      branchDelay <= branchDelayNext;
    end
  end

endmodule

`default_nettype wire

//--- verilog/stepControl.sv
`default_nettype none

module stepControl (
  input  decoderPkg::stepT       step,
  input  logic                   branchDelay,
  input  decoderPkg::instrClassT instrClass,
  input  decoderPkg::aluCtrlT    aluOp,
  output logic                   memRead,
  output logic                   memWrite,
  output logic                   irWrite,
  output logic                   pcWrite,
  output logic                   pcSrc,
  output logic                   iorD,
  output logic                   aluSrcA,
  output decoderPkg::aluSrcBT    aluSrcB,
  output decoderPkg::aluCtrlT    aluControl,
  output logic                   aluSel,
  output logic                   regWrite,
  output logic                   memToReg,
  output logic                   regDst
);

  always_comb begin
    memRead    = 1'b0;
    memWrite   = 1'b0;
    irWrite    = 1'b0;
    pcWrite    = 1'b0;
    pcSrc      = 1'b0;
    iorD       = 1'b0;
    aluSrcA    = 1'b0;
    aluSrcB    = decoderPkg::srcBReg;
    aluControl = decoderPkg::aluAdd;
    aluSel     = 1'b0;
    regWrite   = 1'b0;
    memToReg   = 1'b0;
    // Immediate forms only, so rt is always the destination
    regDst     = 1'b0;

    case (step)
      decoderPkg::stFetch: begin
        // PC + 4, or the target held in the ALU register
        memRead = 1'b1;
        pcWrite = 1'b1;
        pcSrc   = branchDelay;
        aluSrcB = decoderPkg::srcBFour;
      end
      decoderPkg::stMemWait: begin
        memRead = 1'b1;
      end
      decoderPkg::stDecode: begin
        // Branch target computed early from PC and offset
        irWrite    = 1'b1;
        aluSrcB    = decoderPkg::srcBShift;
        aluControl = decoderPkg::aluBranchTarget;
      end
      decoderPkg::stExec1: begin
        case (instrClass)
          decoderPkg::clsAluImm,
          decoderPkg::clsLoad,
          decoderPkg::clsStore: begin
            aluSrcA    = 1'b1;
            aluSrcB    = decoderPkg::srcBImm;
            aluControl = aluOp;
          end
          decoderPkg::clsBranchEq,
          decoderPkg::clsBranchNe: begin
            aluSrcA    = 1'b1;
            aluSrcB    = decoderPkg::srcBReg;
            aluControl = decoderPkg::aluCmpEq;
            aluSel     = 1'b1;
          end
          decoderPkg::clsJump: begin
            aluSrcB    = decoderPkg::srcBShift;
            aluControl = decoderPkg::aluPassB;
          end
          default: aluControl = decoderPkg::aluAdd;
        endcase
      end
      decoderPkg::stExec2: begin
        case (instrClass)
          decoderPkg::clsLoad: begin
            memRead = 1'b1;
            iorD    = 1'b1;
            aluSel  = 1'b1;
          end
          decoderPkg::clsStore: begin
            memWrite = 1'b1;
            iorD     = 1'b1;
          end
          decoderPkg::clsAluImm: begin
            regWrite = 1'b1;
            memToReg = 1'b1;
            aluSel   = 1'b1;
          end
          default: regWrite = 1'b0;
        endcase
      end
      decoderPkg::stExec3: begin
        // Load data written back from the memory path
        regWrite = (instrClass == decoderPkg::clsLoad);
      end
      default: regWrite = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/decoderTop.sv
`default_nettype none

module decoderTop (
  input  logic                clk,
  input  logic                reset,
  input  decoderPkg::instrT   instr,
  input  logic                waitRequest,
  input  logic                outLsb,
  input  logic                pcIsZero,
  output logic                memRead,
  output logic                memWrite,
  output decoderPkg::byteEnT  byteEnable,
  output decoderPkg::extModeT extendMode,
  output logic                irWrite,
  output logic                pcWrite,
  output logic                pcSrc,
  output logic                iorD,
  output logic                aluSrcA,
  output decoderPkg::aluSrcBT aluSrcB,
  output decoderPkg::aluCtrlT aluControl,
  output logic                aluSel,
  output logic                extSel,
  output logic                regWrite,
  output logic                memToReg,
  output logic                regDst,
  output logic                active,
  output decoderPkg::stepT    step,
  output logic                branchDelay
);

  decoderPkg::opcodeT     opcode;
  decoderPkg::instrClassT instrClass;
  decoderPkg::aluCtrlT    aluOp;

  assign opcode = instr[decoderPkg::opcodeMsb:decoderPkg::opcodeLsb];

  opcodeClassifier classifier0 (
    .opcode     (opcode),
    .instrClass (instrClass),
    .aluOp      (aluOp),
    .extSel     (extSel),
    .byteEnable (byteEnable),
    .extendMode (extendMode)
  );

  controlSequencer sequencer0 (
    .clk         (clk),
    .reset       (reset),
    .instrClass  (instrClass),
    .waitRequest (waitRequest),
    .outLsb      (outLsb),
    .pcIsZero    (pcIsZero),
    .step        (step),
    .branchDelay (branchDelay),
    .active      (active)
  );

  stepControl control0 (
    .step        (step),
    .branchDelay (branchDelay),
    .instrClass  (instrClass),
    .aluOp       (aluOp),
    .memRead     (memRead),
    .memWrite    (memWrite),
    .irWrite     (irWrite),
    .pcWrite     (pcWrite),
    .pcSrc       (pcSrc),
    .iorD        (iorD),
    .aluSrcA     (aluSrcA),
    .aluSrcB     (aluSrcB),
    .aluControl  (aluControl),
    .aluSel      (aluSel),
    .regWrite    (regWrite),
    .memToReg    (memToReg),
    .regDst      (regDst)
  );

endmodule

`default_nettype wire

//--- verif/clockGen.sv
`default_nettype none

module clockGen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reset held for 8 cycles, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- verif/decoderSva.sv
`default_nettype none

module decoderAssertions (
  input logic                clk,
  input logic                reset,
  input decoderPkg::instrT   instr,
  input logic                waitRequest,
  input logic                outLsb,
  input logic                pcIsZero,
  input decoderPkg::stepT    step,
  input logic                memRead,
  input logic                memWrite,
  input decoderPkg::byteEnT  byteEnable,
  input decoderPkg::extModeT extendMode,
  input logic                irWrite,
  input logic                pcWrite,
  input logic                pcSrc,
  input logic                iorD,
  input logic                aluSrcA,
  input decoderPkg::aluSrcBT aluSrcB,
  input decoderPkg::aluCtrlT aluControl,
  input logic                aluSel,
  input logic                extSel,
  input logic                regWrite,
  input logic                memToReg,
  input logic                regDst,
  input logic                active,
  input logic                branchDelay
);

  int                  failCount = 0;
  decoderPkg::opcodeT  op;
  logic                isLoad;
  logic                isStore;
  logic                isLogic;
  logic                isAluImm;
  logic                isFlow;
  logic                extra;
  logic                taken;
  logic                takenPrev;
  logic                expectSrcA;
  decoderPkg::aluSrcBT expectSrcB;
  decoderPkg::byteEnT  expectBe;
  decoderPkg::extModeT expectMode;
  decoderPkg::stepT    expectNext;
  decoderPkg::stepT    expectPrev;
  decoderPkg::stepT    stepPrev;

  function automatic decoderPkg::aluCtrlT execAluCode(input decoderPkg::opcodeT code);
    case (code)
      decoderPkg::opAndi:                   return decoderPkg::aluAnd;
      decoderPkg::opOri:                    return decoderPkg::aluOr;
      decoderPkg::opXori:                   return decoderPkg::aluXor;
      decoderPkg::opBeq, decoderPkg::opBne: return decoderPkg::aluCmpEq;
      decoderPkg::opJ:                      return decoderPkg::aluPassB;
      default:                              return decoderPkg::aluAdd;
    endcase
  endfunction

  // Next step of a running instruction, halt aside
  function automatic decoderPkg::stepT stepAfter(input decoderPkg::stepT cur, input logic busy,
                                                 input logic load, input logic more);
    case (cur)
      decoderPkg::stFetch,
      decoderPkg::stMemWait: return busy ? decoderPkg::stMemWait : decoderPkg::stDecode;
      decoderPkg::stDecode:  return decoderPkg::stExec1;
      decoderPkg::stExec1:   return more ? decoderPkg::stExec2 : decoderPkg::stFetch;
      decoderPkg::stExec2: begin
        if (!load) return decoderPkg::stFetch;
        return busy ? decoderPkg::stExec2 : decoderPkg::stExec3;
      end
      default:               return decoderPkg::stFetch;
    endcase
  endfunction

  // B operand per step, PC + 4 in fetch and the offset in decode
  function automatic decoderPkg::aluSrcBT operandB(input decoderPkg::stepT cur,
                                                   input logic more, input logic jump);
    case (cur)
      decoderPkg::stFetch:  return decoderPkg::srcBFour;
      decoderPkg::stDecode: return decoderPkg::srcBShift;
      decoderPkg::stExec1: begin
        if (jump) return decoderPkg::srcBShift;
        return more ? decoderPkg::srcBImm : decoderPkg::srcBReg;
      end
      default:              return decoderPkg::srcBReg;
    endcase
  endfunction

  task automatic recordFailure(input string msg);
    failCount++;
    $error("%s", msg);
  endtask

  assign op         = instr[decoderPkg::opcodeMsb:decoderPkg::opcodeLsb];
  assign isLoad     = op inside {decoderPkg::opLw, decoderPkg::opLb, decoderPkg::opLbu};
  assign isStore    = (op == decoderPkg::opSw);
  assign isLogic    = op inside {decoderPkg::opAndi, decoderPkg::opOri, decoderPkg::opXori};
  assign isAluImm   = isLogic || (op == decoderPkg::opAddiu);
  assign isFlow     = op inside {decoderPkg::opBeq, decoderPkg::opBne, decoderPkg::opJ};
  assign extra      = isLoad || isStore || isAluImm;
  // Branch decision taken at the end of the first execute step
  assign taken      = (op == decoderPkg::opJ) || ((op == decoderPkg::opBeq) && outLsb) ||
                      ((op == decoderPkg::opBne) && !outLsb);
  assign expectBe   = (op == decoderPkg::opLw) ? 4'b1111 : 4'b0001;
  assign expectMode = (op == decoderPkg::opLb) ? decoderPkg::extSignByte : decoderPkg::extNone;
  assign expectNext = stepAfter(step, waitRequest, isLoad, extra);
  assign expectSrcB = operandB(step, extra, op == decoderPkg::opJ);
  // Register operand for immediates, addresses and compares
  assign expectSrcA = (step == decoderPkg::stExec1) &&
                      (extra || (isFlow && op != decoderPkg::opJ));

  always_ff @(posedge clk) begin
    expectPrev <= expectNext;
    stepPrev   <= step;
    takenPrev  <= (step == decoderPkg::stExec1) && taken;
  end

  resetState: assert property (@(posedge clk) reset |=> step == decoderPkg::stFetch &&
      !branchDelay && memRead && pcWrite && !memWrite && !regWrite)
    else recordFailure($sformatf("ERR resetState expected step %0d actual %0d",
                                 decoderPkg::stFetch, $sampled(step)));

  fetchRead: assert property (@(posedge clk) disable iff (reset)
      step inside {decoderPkg::stFetch, decoderPkg::stMemWait} |->
      memRead && (pcWrite || step == decoderPkg::stMemWait))
    else recordFailure($sformatf("ERR fetchRead expected 11 actual %b%b",
                                 $sampled(memRead), $sampled(pcWrite)));

  nextStep: assert property (@(posedge clk) disable iff (reset)
      (!pcIsZero && step != decoderPkg::stHalted) |=> step == expectPrev)
    else recordFailure($sformatf("ERR nextStep expected %0d actual %0d",
                                 $sampled(expectPrev), $sampled(step)));

  loadRead: assert property (@(posedge clk) disable iff (reset)
      (step == decoderPkg::stExec2 && isLoad) |-> memRead && iorD && byteEnable == expectBe)
    else recordFailure($sformatf("ERR loadRead expected 11 %h actual %b%b %h",
                                 $sampled(expectBe), $sampled(memRead), $sampled(iorD),
                                 $sampled(byteEnable)));

  modes: assert property (@(posedge clk) disable iff (reset)
      {extSel, extendMode} == {isLogic, expectMode})
    else recordFailure($sformatf("ERR modes expected %h actual %h",
                                 $sampled({isLogic, expectMode}),
                                 $sampled({extSel, extendMode})));

  storeWrite: assert property (@(posedge clk) disable iff (reset)
      (memWrite == (step == decoderPkg::stExec2 && isStore)) && (!memWrite || iorD))
    else recordFailure($sformatf("ERR storeWrite expected %b actual %b",
                                 $sampled(step == decoderPkg::stExec2 && isStore),
                                 $sampled(memWrite)));

  regWriteWhen: assert property (@(posedge clk) disable iff (reset)
      regWrite == ((step == decoderPkg::stExec3 && isLoad) ||
                   (step == decoderPkg::stExec2 && isAluImm)))
    else recordFailure($sformatf("ERR regWriteWhen expected %b actual %b",
                                 $sampled((step == decoderPkg::stExec3 && isLoad) ||
                                          (step == decoderPkg::stExec2 && isAluImm)),
                                 $sampled(regWrite)));

  regWriteSrc: assert property (@(posedge clk) disable iff (reset)
      regWrite |-> memToReg == (step == decoderPkg::stExec2))
    else recordFailure($sformatf("ERR regWriteSrc expected %b actual %b",
                                 $sampled(step == decoderPkg::stExec2), $sampled(memToReg)));

  aluExec1: assert property (@(posedge clk) disable iff (reset)
      (step == decoderPkg::stExec1 && (extra || isFlow)) |-> aluControl == execAluCode(op))
    else recordFailure($sformatf("ERR aluExec1 expected %h actual %h",
                                 execAluCode($sampled(op)), $sampled(aluControl)));

  operandSel: assert property (@(posedge clk) disable iff (reset)
      aluSrcB == expectSrcB && aluSrcA == expectSrcA)
    else recordFailure($sformatf("ERR operandSel expected %0d %b actual %0d %b",
                                 $sampled(expectSrcB), $sampled(expectSrcA),
                                 $sampled(aluSrcB), $sampled(aluSrcA)));

  // Instruction latch and target add in decode, ALU result select only while executing
  stepSelects: assert property (@(posedge clk) disable iff (reset)
      irWrite == (step == decoderPkg::stDecode) && !regDst &&
      (step != decoderPkg::stDecode || aluControl == decoderPkg::aluBranchTarget) &&
      (!aluSel ||
       step inside {decoderPkg::stExec1, decoderPkg::stExec2, decoderPkg::stExec3}))
    else recordFailure($sformatf(
        "ERR stepSelects expected irWrite %b regDst 0 actual irWrite %b regDst %b %b %h",
        $sampled(step == decoderPkg::stDecode), $sampled(irWrite), $sampled(regDst),
        $sampled(aluSel), $sampled(aluControl)));

  branchFetch: assert property (@(posedge clk) disable iff (reset)
      (step == decoderPkg::stFetch &&
       stepPrev inside {decoderPkg::stExec1, decoderPkg::stExec2, decoderPkg::stExec3})
      |-> pcSrc == takenPrev)
    else recordFailure($sformatf("ERR branchFetch expected %b actual %b",
                                 $sampled(takenPrev), $sampled(pcSrc)));

  haltHold: assert property (@(posedge clk) disable iff (reset)
      (pcIsZero || step == decoderPkg::stHalted) |=> step == decoderPkg::stHalted)
    else recordFailure($sformatf("ERR haltHold expected %0d actual %0d",
                                 decoderPkg::stHalted, $sampled(step)));

  haltQuiet: assert property (@(posedge clk) disable iff (reset)
      step == decoderPkg::stHalted |-> !active && !memRead && !memWrite && !regWrite)
    else recordFailure($sformatf("ERR haltQuiet expected 0000 actual %b%b%b%b",
                                 $sampled(active), $sampled(memRead), $sampled(memWrite),
                                 $sampled(regWrite)));

endmodule

bind decoderTop decoderAssertions sva0 (.*);

`default_nettype wire

//--- verif/decoderTb.sv
`default_nettype none

module decoderTb;

  localparam int seed        = 32'h55a7;
  localparam int stepTimeout = 64;
  localparam int numInstr    = 300;

  logic                clk;
  logic                reset;
  decoderPkg::instrT   instr;
  logic                waitRequest;
  logic                outLsb;
  logic                pcIsZero;
  logic                memRead;
  logic                memWrite;
  decoderPkg::byteEnT  byteEnable;
  decoderPkg::extModeT extendMode;
  logic                irWrite;
  logic                pcWrite;
  logic                pcSrc;
  logic                iorD;
  logic                aluSrcA;
  decoderPkg::aluSrcBT aluSrcB;
  decoderPkg::aluCtrlT aluControl;
  logic                aluSel;
  logic                extSel;
  logic                regWrite;
  logic                memToReg;
  logic                regDst;
  logic                active;
  decoderPkg::stepT    step;
  logic                branchDelay;

  clockGen clockGen0 (
    .clk   (clk),
    .reset (reset)
  );

  decoderTop dut0 (.*);

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // Memory stalls about one cycle in four
  task automatic advanceCycle();
    @(negedge clk);
    waitRequest = (($urandom % 4) == 0);
    outLsb      = $urandom % 2;
  endtask

  task automatic waitForStep(input decoderPkg::stepT target, input string what);
    int count;
    count = 0;
    while (step !== target) begin
      if (count == stepTimeout) begin
        abortRun($sformatf("Timed out waiting for %s", what));
      end
      advanceCycle();
      count++;
    end
  endtask

  function automatic decoderPkg::instrT randomInstr();
    decoderPkg::opcodeT ops[12];
    logic [25:0]        rest;
    ops = '{decoderPkg::opAddiu, decoderPkg::opAndi, decoderPkg::opOri, decoderPkg::opXori,
            decoderPkg::opLw, decoderPkg::opLb, decoderPkg::opLbu, decoderPkg::opSw,
            decoderPkg::opBeq, decoderPkg::opBne, decoderPkg::opJ, 6'b111111};
    rest = $urandom;
    return {ops[$urandom % 12], rest};
  endfunction

  always @(negedge clk) begin
    if (dut0.sva0.failCount != 0) begin
      abortRun("A bound assertion failed");
    end
  end

  initial begin : stimulus
    int count;
    instr       = '0;
    waitRequest = 1'b0;
    outLsb      = 1'b0;
    pcIsZero    = 1'b0;
    void'($urandom(seed));

    count = 0;
    while (reset !== 1'b0) begin
      if (count == stepTimeout) begin
        abortRun("Reset was never released");
      end
      advanceCycle();
      count++;
    end

    // New instruction word each fetch
    for (int i = 0; i < numInstr; i++) begin
      waitForStep(decoderPkg::stFetch, "the next fetch");
      instr = randomInstr();
      advanceCycle();
    end

    pcIsZero = 1'b1;
    advanceCycle();
    if (step !== decoderPkg::stHalted) begin
      abortRun($sformatf("ERR haltEntry expected %0d actual %0d", decoderPkg::stHalted, step));
    end
    repeat (6) advanceCycle();
    if ({active, memRead, memWrite, regWrite} !== 4'b0000) begin
      abortRun($sformatf("ERR haltOutputs expected 0000 actual %b%b%b%b",
                         active, memRead, memWrite, regWrite));
    end

    if (dut0.sva0.failCount != 0) begin
      abortRun("Assertion failures were counted by the end of the run");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- flist.f
verilog/decoderPkg.sv
verilog/opcodeClassifier.sv
verilog/controlSequencer.sv
verilog/stepControl.sv
verilog/decoderTop.sv
verif/clockGen.sv
verif/decoderSva.sv
verif/decoderTb.sv

//--- Bender.yml
package:
  name: decoder

dependencies: {}

sources:
  # Design
  - verilog/decoderPkg.sv
  - verilog/opcodeClassifier.sv
  - verilog/controlSequencer.sv
  - verilog/stepControl.sv
  - verilog/decoderTop.sv

  # Verification
  - target: simulation
    files:
      - verif/clockGen.sv
      - verif/decoderSva.sv
      - verif/decoderTb.sv
